//--- source/spi_regs_pkg.sv
// frame layout and register map for the SPI register target
// imported by every RTL block that decodes frames or registers
`default_nettype none

package spi_regs_pkg;

  // frame geometry
  localparam int FRAME_W   = 32;
  localparam int BIT_CNT_W = 5;   // counts 0..31 within a frame

  // command fields
  localparam int ADDR_W   = 4;
  localparam int DATA_W   = 16;   // data sits in frame bits 15:0
  localparam int WR_BIT   = 31;
  localparam int ADDR_LSB = 24;   // address in frame bits 27:24

  // register map
  // 0..3 control, 4 pulse, 5..7 unused, 8 status, 9 frame count, 10..15 scratch
  localparam int N_CTRL          = 4;
  localparam int ADDR_PULSE      = 4;
  localparam int ADDR_STATUS     = 8;
  localparam int ADDR_FCOUNT     = 9;
  localparam int ADDR_SCRATCH_LO = 10;
  localparam int N_SCRATCH       = 6;

endpackage

`default_nettype wire

//--- source/reg_wr_if.sv
// register write and readback link from the command executor to the control bank
// executor takes the master side, bank the slave side
`timescale 1ns/1ps
`default_nettype none

interface reg_wr_if;
  import spi_regs_pkg::*;

  logic              wr_stb;   // single clk pulse per bank write
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] rd_data;  // comb readback of the register at wr_addr

  modport master (
    output wr_stb,
    output wr_addr,
    output wr_data,
    input  rd_data
  );

  modport slave (
    input  wr_stb,
    input  wr_addr,
    input  wr_data,
    output rd_data
  );

endinterface

`default_nettype wire

//--- source/spi_frame_port.sv
// SPI target shift port, oversampled on clk (mode 0, MSB first)
// rx_stb pulses with each received frame; tx_word goes out on miso in the next frame
`timescale 1ns/1ps
`default_nettype none

module spi_frame_port (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               ss,
  input  wire                               sck,
  input  wire                               mosi,
  output logic                              miso,
  output logic                              rx_stb,
  output logic [spi_regs_pkg::FRAME_W-1:0]  rx_word,
  input  wire  [spi_regs_pkg::FRAME_W-1:0]  tx_word
);
  import spi_regs_pkg::*;

  // two-flop samplers on the async pins
  logic [1:0]           ss_sync;
  logic [1:0]           sck_sync;
  logic [1:0]           mosi_sync;
  logic                 sck_old;    // previous sampled sck, for edge detect

  logic                 ss_in;
  logic                 sck_in;
  logic                 mosi_in;
  logic                 sck_rise;
  logic                 sck_fall;

  logic [FRAME_W-1:0]   shift_q;
  logic [FRAME_W-1:0]   shift_d;
  logic [BIT_CNT_W-1:0] bit_cnt_q;
  logic [BIT_CNT_W-1:0] bit_cnt_d;
  logic                 miso_d;
  logic                 rx_stb_d;
  logic [FRAME_W-1:0]   rx_word_d;

  assign ss_in    = ss_sync[1];
  assign sck_in   = sck_sync[1];
  assign mosi_in  = mosi_sync[1];
  assign sck_rise = !sck_old && sck_in;
  assign sck_fall = sck_old && !sck_in;

  always_comb begin
    shift_d   = shift_q;
    bit_cnt_d = bit_cnt_q;
    miso_d    = miso;
    rx_stb_d  = 1'b0;
    rx_word_d = rx_word;

    if (ss_in) begin
      // keep reloading between frames so the next response is ready
      bit_cnt_d = '0;
      shift_d   = tx_word;
      miso_d    = shift_q[FRAME_W-1];
    end else if (sck_rise) begin
      shift_d   = {shift_q[FRAME_W-2:0], mosi_in};
      bit_cnt_d = bit_cnt_q + 1'b1;   // wraps to 0 after bit 31
      if (bit_cnt_q == BIT_CNT_W'(FRAME_W - 1)) begin
        rx_word_d = {shift_q[FRAME_W-2:0], mosi_in};
        rx_stb_d  = 1'b1;
        shift_d   = tx_word;
      end
    end else if (sck_fall) begin
      miso_d = shift_q[FRAME_W-1];    // master samples on the next rising edge
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ss_sync   <= 2'b11;   // deselected
      sck_sync  <= 2'b00;
      sck_old   <= 1'b0;
      bit_cnt_q <= '0;
      rx_stb    <= 1'b0;
      miso      <= 1'b1;
    end else begin
      ss_sync   <= {ss_sync[0], ss};
      sck_sync  <= {sck_sync[0], sck};
      sck_old   <= sck_in;
      bit_cnt_q <= bit_cnt_d;
      rx_stb    <= rx_stb_d;
      miso      <= miso_d;
    end

    mosi_sync <= {mosi_sync[0], mosi};
    shift_q   <= shift_d;
    rx_word   <= rx_word_d;   // held until the next strobe
  end

endmodule

`default_nettype wire

//--- source/spi_cmd_exec.sv
// executes one register command per received frame
// scratch and frame counter live here, control/pulse writes go out over reg_wr_if
// response = upper frame half plus the post-write value, loaded for the next frame
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_exec (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               rx_stb,
  input  wire  [spi_regs_pkg::FRAME_W-1:0]  rx_word,
  output logic [spi_regs_pkg::FRAME_W-1:0]  tx_word,
  input  wire  [spi_regs_pkg::DATA_W-1:0]   status_in,
  reg_wr_if.master                          wr
);
  import spi_regs_pkg::*;

  logic              cmd_wr;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_data;
  logic              bank_hit;   // addresses 0..4 are owned by the control bank
  logic              pulse_hit;

  logic [DATA_W-1:0] scratch_q [N_SCRATCH];
  logic [DATA_W-1:0] fcount_q;
  logic [DATA_W-1:0] fcount_next;
  logic [DATA_W-1:0] rd_value;

  // frame decode; rx_word stays put until the next strobe
  assign cmd_wr      = rx_word[WR_BIT];
  assign cmd_addr    = rx_word[ADDR_LSB +: ADDR_W];
  assign cmd_data    = rx_word[DATA_W-1:0];
  assign bank_hit    = cmd_addr <= ADDR_W'(ADDR_PULSE);
  assign pulse_hit   = cmd_addr == ADDR_W'(ADDR_PULSE);
  assign fcount_next = fcount_q + 1'b1;   // includes the frame being executed

  // bank sees the address right away, so rd_data is valid in the strobe cycle
  assign wr.wr_addr = cmd_addr;
  assign wr.wr_data = cmd_data;

  // value at the address once this command's own write has landed
  always_comb begin
    rd_value = '0;   // 5..7 and anything unmapped
    if (bank_hit) begin
      // pulse register always reads back 0 from the bank
      rd_value = (cmd_wr && !pulse_hit) ? cmd_data : wr.rd_data;
    end else if (cmd_addr == ADDR_W'(ADDR_STATUS)) begin
      rd_value = status_in;
    end else if (cmd_addr == ADDR_W'(ADDR_FCOUNT)) begin
      rd_value = fcount_next;
    end else begin
      for (int i = 0; i < N_SCRATCH; i++) begin
        if (cmd_addr == ADDR_W'(ADDR_SCRATCH_LO + i)) begin
          rd_value = cmd_wr ? cmd_data : scratch_q[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr.wr_stb <= 1'b0;
      tx_word   <= '0;   // first frame after reset answers with zeros
      fcount_q  <= '0;
      for (int i = 0; i < N_SCRATCH; i++) begin
        scratch_q[i] <= '0;
      end
    end else begin
      wr.wr_stb <= rx_stb && cmd_wr && bank_hit;
      if (rx_stb) begin
        fcount_q <= fcount_next;
        tx_word  <= {rx_word[FRAME_W-1:DATA_W], rd_value};
        for (int i = 0; i < N_SCRATCH; i++) begin
          if (cmd_wr && cmd_addr == ADDR_W'(ADDR_SCRATCH_LO + i)) begin
            scratch_q[i] <= cmd_data;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/ctrl_out_bank.sv
// control registers 0..3 and the self-clearing pulse register at address 4
// written over reg_wr_if, outputs go straight to the pins
`timescale 1ns/1ps
`default_nettype none

module ctrl_out_bank (
  input  wire                                                    clk,
  input  wire                                                    rst,
  reg_wr_if.slave                                                bus,
  output logic [spi_regs_pkg::N_CTRL*spi_regs_pkg::DATA_W-1:0]   ctrl_out,
  output logic [spi_regs_pkg::DATA_W-1:0]                        pulse_out
);
  import spi_regs_pkg::*;

  logic [DATA_W-1:0] ctrl_q [N_CTRL];
  logic              pulse_hit;

  assign pulse_hit = bus.wr_stb && (bus.wr_addr == ADDR_W'(ADDR_PULSE));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N_CTRL; i++) begin
        ctrl_q[i] <= '0;
      end
      pulse_out <= '0;
    end else begin
      for (int i = 0; i < N_CTRL; i++) begin
        if (bus.wr_stb && bus.wr_addr == ADDR_W'(i)) begin
          ctrl_q[i] <= bus.wr_data;
        end
      end
      pulse_out <= pulse_hit ? bus.wr_data : '0;   // high for one clk only
    end
  end

  // readback for 0..3; pulse register and other addresses read 0
  always_comb begin
    bus.rd_data = '0;
    for (int i = 0; i < N_CTRL; i++) begin
      if (bus.wr_addr == ADDR_W'(i)) begin
        bus.rd_data = ctrl_q[i];
      end
    end
  end

  // register 0 in the low bits
  always_comb begin
    for (int i = 0; i < N_CTRL; i++) begin
      ctrl_out[i*DATA_W +: DATA_W] = ctrl_q[i];
    end
  end

endmodule

`default_nettype wire

//--- source/spi_reg_top.sv
// SPI register target: frame port, command executor and control output bank
// plain pins in and out, SPI mode 0 with sck at least 8x slower than clk
`timescale 1ns/1ps
`default_nettype none

module spi_reg_top (
  input  wire                                                    clk,
  input  wire                                                    rst,
  input  wire                                                    ss,
  input  wire                                                    sck,
  input  wire                                                    mosi,
  output logic                                                   miso,
  input  wire  [spi_regs_pkg::DATA_W-1:0]                        status_in,
  output logic [spi_regs_pkg::N_CTRL*spi_regs_pkg::DATA_W-1:0]   ctrl_out,
  output logic [spi_regs_pkg::DATA_W-1:0]                        pulse_out
);
  import spi_regs_pkg::*;

  logic               rx_stb;
  logic [FRAME_W-1:0] rx_word;
  logic [FRAME_W-1:0] tx_word;   // response for the next frame

  reg_wr_if wr_bus ();

  spi_frame_port u_frame_port (
    .clk     (clk),
    .rst     (rst),
    .ss      (ss),
    .sck     (sck),
    .mosi    (mosi),
    .miso    (miso),
    .rx_stb  (rx_stb),
    .rx_word (rx_word),
    .tx_word (tx_word)
  );

  spi_cmd_exec u_cmd_exec (
    .clk       (clk),
    .rst       (rst),
    .rx_stb    (rx_stb),
    .rx_word   (rx_word),
    .tx_word   (tx_word),
    .status_in (status_in),
    .wr        (wr_bus.master)
  );

  ctrl_out_bank u_ctrl_bank (
    .clk       (clk),
    .rst       (rst),
    .bus       (wr_bus.slave),
    .ctrl_out  (ctrl_out),
    .pulse_out (pulse_out)
  );

endmodule

`default_nettype wire

//--- sim/spi_reg_checker.sv
// compares each reported SPI frame and the control pins with the testbench model
// counts pulse_out high cycles between reports; samples on the falling clk edge
`timescale 1ns/1ps
`default_nettype none

module spi_reg_checker (
  input  wire                                                  clk,
  input  wire                                                  rst,
  input  wire  [spi_regs_pkg::N_CTRL*spi_regs_pkg::DATA_W-1:0] ctrl_out,
  input  wire  [spi_regs_pkg::DATA_W-1:0]                      pulse_out,
  input  wire                                                  frame_done,  // fields below valid
  input  wire  [spi_regs_pkg::FRAME_W-1:0]                     rx_got,
  input  wire  [spi_regs_pkg::FRAME_W-1:0]                     rx_exp,
  input  wire  [spi_regs_pkg::N_CTRL*spi_regs_pkg::DATA_W-1:0] ctrl_exp,
  input  wire  [spi_regs_pkg::DATA_W-1:0]                      pulse_exp,
  input  wire                                                  test_done,
  input  wire  [2:0]                                           test_num,
  input  wire                                                  run_done,
  output logic [31:0]                                          check_total,
  output logic [31:0]                                          err_total
);
  import spi_regs_pkg::*;

  logic [31:0]       test_checks;
  logic [31:0]       test_errs;
  logic [31:0]       pulse_cycles;   // clk cycles with any pulse bit high
  logic [DATA_W-1:0] pulse_seen;

  function automatic string test_name(input logic [2:0] n);
    case (n)
      3'd1:    return "write and read back";
      3'd2:    return "control outputs";
      3'd3:    return "pulse register";
      3'd4:    return "status and unused";
      3'd5:    return "frame counter";
      default: return "random frames";
    endcase
  endfunction

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_total = check_total + 32'd1;
    test_checks = test_checks + 32'd1;
    if (got !== exp) begin
      err_total = err_total + 32'd1;
      test_errs = test_errs + 32'd1;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      check_total  = '0;
      err_total    = '0;
      test_checks  = '0;
      test_errs    = '0;
      pulse_cycles = '0;
      pulse_seen   = '0;
    end else if (frame_done) begin
      compare("response", 64'(rx_got), 64'(rx_exp));
      compare("ctrl_out", ctrl_out, ctrl_exp);
      compare("pulse bits", 64'(pulse_seen), 64'(pulse_exp));
      compare("pulse cycles", 64'(pulse_cycles), (pulse_exp != '0) ? 64'd1 : 64'd0);
      pulse_cycles = '0;
      pulse_seen   = '0;
    end else begin
      if (pulse_out != '0) begin
        pulse_cycles = pulse_cycles + 32'd1;
        pulse_seen   = pulse_seen | pulse_out;
      end
      if (test_done) begin
        $display("test %0d (%s): %0d checks, %0d errors, %s", test_num, test_name(test_num),
                 test_checks, test_errs, (test_errs == '0) ? "ok" : "FAILED");
        test_checks = '0;
        test_errs   = '0;
      end
      if (run_done) begin
        $display("total: %0d checks, %0d errors", check_total, err_total);
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_spi_reg_top.sv
// SPI mode 0 master, register map model and random frames for spi_reg_top
// spi_reg_checker does the comparing; build with vlog.f from the project root
`timescale 1ns/1ps
`default_nettype none

module tb_spi_reg_top;
  import spi_regs_pkg::*;

  localparam int HALF_SCK   = 8;   // clk per sck half period
  localparam int SS_GAP     = 6;
  localparam int N_RW       = N_CTRL + N_SCRATCH;
  localparam int T1_FRAMES  = 2 * N_RW;
  localparam int T2_FRAMES  = 2 * N_CTRL;
  localparam int T3_FRAMES  = 6;
  localparam int T4_FRAMES  = 12;
  localparam int T5_FRAMES  = 4;
  localparam int T6_FRAMES  = 201;  // last one only collects the previous response
  localparam int N_FRAMES   = T1_FRAMES + T2_FRAMES + T3_FRAMES + T4_FRAMES + T5_FRAMES
                              + T6_FRAMES;
  localparam int MAX_CYCLES = N_FRAMES * 600 + 200;

  logic                     clk;
  logic                     rst;
  logic                     ss;
  logic                     sck;
  logic                     mosi;
  logic                     miso;
  logic [DATA_W-1:0]        status_in;
  logic [N_CTRL*DATA_W-1:0] ctrl_out;
  logic [DATA_W-1:0]        pulse_out;

  logic                     frame_done;
  logic [FRAME_W-1:0]       rx_got;
  logic [FRAME_W-1:0]       rx_exp;
  logic [N_CTRL*DATA_W-1:0] ctrl_exp;
  logic [DATA_W-1:0]        pulse_exp;
  logic                     test_done;
  logic [2:0]               test_num;
  logic                     run_done;
  logic [31:0]              check_total;
  logic [31:0]              err_total;

  // register map model
  logic [DATA_W-1:0]        ctrl_m [N_CTRL];
  logic [DATA_W-1:0]        scratch_m [N_SCRATCH];
  logic [DATA_W-1:0]        fcount_m;
  logic [FRAME_W-1:0]       exp_next;   // response due in the next frame
  logic [31:0]              lcg_state;
  int                       cycle_cnt = 0;

  spi_reg_top u_spi_reg_top (
    .clk       (clk),
    .rst       (rst),
    .ss        (ss),
    .sck       (sck),
    .mosi      (mosi),
    .miso      (miso),
    .status_in (status_in),
    .ctrl_out  (ctrl_out),
    .pulse_out (pulse_out)
  );

  spi_reg_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .ctrl_out    (ctrl_out),
    .pulse_out   (pulse_out),
    .frame_done  (frame_done),
    .rx_got      (rx_got),
    .rx_exp      (rx_exp),
    .ctrl_exp    (ctrl_exp),
    .pulse_exp   (pulse_exp),
    .test_done   (test_done),
    .test_num    (test_num),
    .run_done    (run_done),
    .check_total (check_total),
    .err_total   (err_total)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];   // low LCG bits repeat quickly
  endfunction

  // control addresses 0..3 then scratch
  function automatic logic [ADDR_W-1:0] rw_addr(input int k);
    return (k < N_CTRL) ? ADDR_W'(k) : ADDR_W'(k - N_CTRL + ADDR_SCRATCH_LO);
  endfunction

  // ignored frame bits get random filler
  function automatic logic [FRAME_W-1:0] make_cmd(input logic wr, input logic [ADDR_W-1:0] addr,
                                                  input logic [DATA_W-1:0] data);
    logic [15:0] junk;
    junk = rand16();
    return {wr, junk[2:0], addr, junk[10:3], data};
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  task automatic spi_transfer(input logic [FRAME_W-1:0] tx, output logic [FRAME_W-1:0] rx);
    logic [FRAME_W-1:0] tx_sh;
    tx_sh = tx;
    rx    = '0;
    ss    = 1'b0;
    wait_clks(HALF_SCK);
    repeat (FRAME_W) begin
      mosi  = tx_sh[FRAME_W-1];
      tx_sh = tx_sh << 1;
      wait_clks(HALF_SCK);
      rx  = {rx[FRAME_W-2:0], miso};   // just before the rising edge
      sck = 1'b1;
      wait_clks(HALF_SCK);
      sck = 1'b0;
    end
    wait_clks(HALF_SCK);
    ss   = 1'b1;
    mosi = 1'b0;
  endtask

  task automatic model_apply(input logic [FRAME_W-1:0] cmd, output logic [DATA_W-1:0] pulse_w);
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] value;
    logic [2:0]        sidx;
    wr       = cmd[WR_BIT];
    addr     = cmd[ADDR_LSB +: ADDR_W];
    data     = cmd[DATA_W-1:0];
    value    = '0;   // 5..7 and the pulse register
    pulse_w  = '0;
    sidx     = 3'(addr - ADDR_W'(ADDR_SCRATCH_LO));
    fcount_m = fcount_m + 16'd1;
    if (addr < ADDR_W'(N_CTRL)) begin
      if (wr) begin
        ctrl_m[addr[1:0]] = data;
      end
      value = ctrl_m[addr[1:0]];
    end else if (addr == ADDR_W'(ADDR_PULSE)) begin
      if (wr) begin
        pulse_w = data;
      end
    end else if (addr == ADDR_W'(ADDR_STATUS)) begin
      value = status_in;
    end else if (addr == ADDR_W'(ADDR_FCOUNT)) begin
      value = fcount_m;
    end else if (addr >= ADDR_W'(ADDR_SCRATCH_LO)) begin
      if (wr) begin
        scratch_m[sidx] = data;
      end
      value = scratch_m[sidx];
    end
    exp_next = {cmd[FRAME_W-1:DATA_W], value};
  endtask

  // one frame and its report to the checker inside the ss gap
  task automatic run_frame(input logic [FRAME_W-1:0] cmd);
    logic [FRAME_W-1:0] rx;
    logic [FRAME_W-1:0] due;
    logic [DATA_W-1:0]  pulse_w;
    due = exp_next;
    spi_transfer(cmd, rx);
    model_apply(cmd, pulse_w);
    wait_clks(1);
    rx_got     = rx;
    rx_exp     = due;
    ctrl_exp   = {ctrl_m[3], ctrl_m[2], ctrl_m[1], ctrl_m[0]};
    pulse_exp  = pulse_w;
    frame_done = 1'b1;
    wait_clks(1);
    frame_done = 1'b0;
    wait_clks(SS_GAP - 2);
  endtask

  task automatic end_test(input logic [2:0] n);
    test_num  = n;
    test_done = 1'b1;
    wait_clks(1);
    test_done = 1'b0;
  endtask

  initial begin
    logic [FRAME_W-1:0] cmd;
    rst        = 1'b1;
    ss         = 1'b1;
    sck        = 1'b0;
    mosi       = 1'b0;
    status_in  = '0;
    frame_done = 1'b0;
    test_done  = 1'b0;
    test_num   = '0;
    run_done   = 1'b0;
    rx_got     = '0;
    rx_exp     = '0;
    ctrl_exp   = '0;
    pulse_exp  = '0;
    ctrl_m     = '{default: '0};
    scratch_m  = '{default: '0};
    fcount_m   = '0;
    exp_next   = '0;   // first frame after reset shifts out zeros
    lcg_state  = 32'd29050;
    repeat (4) @(posedge clk);
    #5;
    rst = 1'b0;
    wait_clks(SS_GAP);

    for (int k = 0; k < N_RW; k++) begin
      run_frame(make_cmd(1'b1, rw_addr(k), rand16()));
    end
    for (int k = 0; k < N_RW; k++) begin
      run_frame(make_cmd(1'b0, rw_addr(k), rand16()));
    end
    end_test(3'd1);

    for (int k = 0; k < T2_FRAMES; k++) begin
      run_frame(make_cmd(1'b1, ADDR_W'(k % N_CTRL), rand16()));
    end
    end_test(3'd2);

    for (int k = 0; k < 4; k++) begin
      run_frame(make_cmd(1'b1, ADDR_W'(ADDR_PULSE), rand16()));
    end
    for (int k = 0; k < 2; k++) begin
      run_frame(make_cmd(1'b0, ADDR_W'(ADDR_PULSE), rand16()));
    end
    end_test(3'd3);

    for (int k = 0; k < 4; k++) begin
      status_in = rand16();
      run_frame(make_cmd(1'b0, ADDR_W'(ADDR_STATUS), rand16()));
    end
    for (int a = 5; a <= 9; a++) begin
      run_frame(make_cmd(1'b1, ADDR_W'(a), rand16()));
    end
    for (int a = 5; a <= 7; a++) begin
      run_frame(make_cmd(1'b0, ADDR_W'(a), rand16()));
    end
    end_test(3'd4);

    for (int k = 0; k < T5_FRAMES; k++) begin
      run_frame(make_cmd(1'b0, ADDR_W'(ADDR_FCOUNT), rand16()));
    end
    end_test(3'd5);

    for (int k = 0; k < T6_FRAMES - 1; k++) begin
      status_in             = rand16();
      cmd[FRAME_W-1:DATA_W] = rand16();
      cmd[DATA_W-1:0]       = rand16();
      run_frame(cmd);
    end
    run_frame(make_cmd(1'b0, ADDR_W'(ADDR_FCOUNT), 16'h0000));
    end_test(3'd6);

    run_done = 1'b1;
    wait_clks(1);
    run_done = 1'b0;
    wait_clks(1);
    if (err_total == '0 && check_total != '0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/spi_regs_pkg.sv
source/reg_wr_if.sv
source/spi_frame_port.sv
source/spi_cmd_exec.sv
source/ctrl_out_bank.sv
source/spi_reg_top.sv
sim/spi_reg_checker.sv
sim/tb_spi_reg_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the SPI register target testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_spi_reg_top \
  -f vlog.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Verification passed" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi
